/* source/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	// Primary opcodes of the supported subset
	typedef enum logic [5:0] {
		op_rtype = 6'h00,
		op_j     = 6'h02,
		op_beq   = 6'h04,
		op_addiu = 6'h09,
		op_ori   = 6'h0d,
		op_lui   = 6'h0f,
		op_lw    = 6'h23,
		op_sw    = 6'h2b
	} opcode_e;

	// R-type funct field
	typedef enum logic [5:0] {
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_slt  = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt,
		alu_lui
	} alu_op_e;

	typedef enum logic {
		wb_alu,
		wb_mem
	} wb_sel_e;

	typedef enum logic [1:0] {
		npc_seq,
		npc_beq,
		npc_jump
	} npc_mode_e;

	typedef enum logic {
		load_im,
		load_dm
	} load_target_e;

	// Immediate is instr[15:0], jump target is instr[25:0]
	typedef struct packed {
		opcode_e    opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funct_e     funct;
	} instr_t;

	typedef struct packed {
		alu_op_e   alu_op;
		logic      alu_src_imm;
		logic      rf_we;
		logic      rf_dst_rd;
		wb_sel_e   wb_sel;
		logic      dm_we;
		npc_mode_e npc_mode;
	} ctrl_t;

	// One loader beat, taken only while the core is stopped
	typedef struct packed {
		logic         valid;
		load_target_e target;
		logic [31:0]  addr;
		logic [31:0]  data;
	} load_t;

	typedef struct packed {
		logic [31:0] pc;
		instr_t      instr;
		logic        rf_we;
		logic [4:0]  rf_waddr;
		logic [31:0] rf_wdata;
		logic        dm_we;
		logic [31:0] dm_addr;
		logic [31:0] dm_wdata;
	} retire_t;

endpackage

`default_nettype wire

/* source/pc_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_unit import cpu_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        run,
	input  instr_t      instr,
	input  npc_mode_e   npc_mode,
	input  logic        equal,
	input  logic [31:0] imm_ext,
	output logic [31:0] pc
);

	logic [31:0] pc_plus4;
	logic [31:0] next_pc;

	assign pc_plus4 = pc + 32'd4;

	// Branch offset counts words from the delay-free next pc
	always_comb begin
		case (npc_mode)
			npc_beq: begin
				if (equal) begin
					next_pc = pc_plus4 + {imm_ext[29:0], 2'b00};
				end else begin
					next_pc = pc_plus4;
				end
			end
			npc_jump: next_pc = {pc_plus4[31:28], instr[25:0], 2'b00};
			default:  next_pc = pc_plus4;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= 32'd0;
		end else if (run) begin
			pc <= next_pc;
		end
	end

endmodule

`default_nettype wire

/* source/im.sv */
`timescale 1ns/1ps
`default_nettype none

module im import cpu_pkg::*; #(
	parameter int IM_AW = 6
) (
	input  logic        clk,
	input  logic        run,
	input  load_t       load,
	input  logic [31:0] pc,
	output instr_t      instr
);

	logic [31:0] mem [2**IM_AW];
	logic        load_we;

	// Loader only writes while the core is stopped
	assign load_we = load.valid && !run && (load.target == load_im);

	always_ff @(posedge clk) begin
		if (load_we) begin
			mem[load.addr[IM_AW+1:2]] <= load.data;
		end
	end

	// Fetch wraps on the word index
	assign instr = mem[pc[IM_AW+1:2]];

endmodule

`default_nettype wire

/* source/control.sv */
`timescale 1ns/1ps
`default_nettype none

module control import cpu_pkg::*; (
	input  instr_t      instr,
	output ctrl_t       ctrl,
	output logic [31:0] imm_ext
);

	logic [15:0] imm;

	assign imm = instr[15:0];

	always_comb begin
		// Inactive word, also used for any unknown code
		ctrl.alu_op      = alu_add;
		ctrl.alu_src_imm = 1'b0;
		ctrl.rf_we       = 1'b0;
		ctrl.rf_dst_rd   = 1'b0;
		ctrl.wb_sel      = wb_alu;
		ctrl.dm_we       = 1'b0;
		ctrl.npc_mode    = npc_seq;

		case (instr.opcode)
			op_rtype: begin
				ctrl.rf_dst_rd = 1'b1;
				case (instr.funct)
					fn_addu: begin
						ctrl.alu_op = alu_add;
						ctrl.rf_we  = 1'b1;
					end
					fn_subu: begin
						ctrl.alu_op = alu_sub;
						ctrl.rf_we  = 1'b1;
					end
					fn_and: begin
						ctrl.alu_op = alu_and;
						ctrl.rf_we  = 1'b1;
					end
					fn_or: begin
						ctrl.alu_op = alu_or;
						ctrl.rf_we  = 1'b1;
					end
					fn_slt: begin
						ctrl.alu_op = alu_slt;
						ctrl.rf_we  = 1'b1;
					end
					default: ctrl.rf_dst_rd = 1'b0;
				endcase
			end
			op_addiu, op_ori, op_lui: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.rf_we       = 1'b1;
				if (instr.opcode == op_ori) begin
					ctrl.alu_op = alu_or;
				end else if (instr.opcode == op_lui) begin
					ctrl.alu_op = alu_lui;
				end
			end
			op_lw: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.rf_we       = 1'b1;
				ctrl.wb_sel      = wb_mem;
			end
			op_sw: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.dm_we       = 1'b1;
			end
			op_beq: begin
				ctrl.alu_op   = alu_sub;
				ctrl.npc_mode = npc_beq;
			end
			op_j: ctrl.npc_mode = npc_jump;
			default: ;
		endcase
	end

	// ori is zero extended, lui lands in the upper half
	always_comb begin
		case (instr.opcode)
			op_ori:  imm_ext = {16'h0000, imm};
			op_lui:  imm_ext = {imm, 16'h0000};
			default: imm_ext = {{16{imm[15]}}, imm};
		endcase
	end

endmodule

`default_nettype wire

/* source/rf.sv */
`timescale 1ns/1ps
`default_nettype none

module rf import cpu_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        run,
	input  instr_t      instr,
	input  ctrl_t       ctrl,
	input  logic [31:0] alu_result,
	input  logic [31:0] dm_rdata,
	output logic [31:0] rs_data,
	output logic [31:0] rt_data,
	output logic [4:0]  waddr,
	output logic [31:0] wdata
);

	logic [31:0] regs [32];

	assign waddr = ctrl.rf_dst_rd ? instr.rd : instr.rt;
	assign wdata = (ctrl.wb_sel == wb_mem) ? dm_rdata : alu_result;

	// r0 always reads zero
	assign rs_data = (instr.rs == 5'd0) ? 32'd0 : regs[instr.rs];
	assign rt_data = (instr.rt == 5'd0) ? 32'd0 : regs[instr.rt];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (run && ctrl.rf_we && (waddr != 5'd0)) begin
			regs[waddr] <= wdata;
		end
	end

endmodule

`default_nettype wire

/* source/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
	input  ctrl_t       ctrl,
	input  logic [31:0] rs_data,
	input  logic [31:0] rt_data,
	input  logic [31:0] imm_ext,
	output logic [31:0] result,
	output logic        equal
);

	logic [31:0] op_b;
	logic        less;

	// Second operand comes from the register or the extended immediate
	assign op_b = ctrl.alu_src_imm ? imm_ext : rt_data;

	assign less = $signed(rs_data) < $signed(op_b);

	always_comb begin
		case (ctrl.alu_op)
			alu_add: result = rs_data + op_b;
			alu_sub: result = rs_data - op_b;
			alu_and: result = rs_data & op_b;
			alu_or:  result = rs_data | op_b;
			alu_slt: result = {31'd0, less};
			// Immediate is already shifted up by the decoder
			alu_lui: result = op_b;
			default: result = 32'd0;
		endcase
	end

	// Branch compare always uses rt, not the immediate
	assign equal = (rs_data == rt_data);

endmodule

`default_nettype wire

/* source/dm.sv */
`timescale 1ns/1ps
`default_nettype none

module dm import cpu_pkg::*; #(
	parameter int DM_AW = 6
) (
	input  logic        clk,
	input  logic        run,
	input  load_t       load,
	input  ctrl_t       ctrl,
	input  logic [31:0] addr,
	input  logic [31:0] wdata,
	output logic [31:0] rdata
);

	logic [31:0] mem [2**DM_AW];
	logic        load_we;
	logic        store_we;

	assign load_we  = load.valid && !run && (load.target == load_dm);
	assign store_we = run && ctrl.dm_we;

	// Loader and sw never overlap since run picks one of them
	always_ff @(posedge clk) begin
		if (load_we) begin
			mem[load.addr[DM_AW+1:2]] <= load.data;
		end else if (store_we) begin
			mem[addr[DM_AW+1:2]] <= wdata;
		end
	end

	assign rdata = mem[addr[DM_AW+1:2]];

endmodule

`default_nettype wire

/* source/cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu import cpu_pkg::*; #(
	parameter int IM_AW = 6,
	parameter int DM_AW = 6
) (
	input  logic    clk,
	input  logic    arst_n,
	input  logic    run,
	input  load_t   load,
	output logic    retire_valid,
	output retire_t retire
);

	logic [31:0] pc;
	instr_t      instr;
	ctrl_t       ctrl;
	logic [31:0] imm_ext;
	logic [31:0] rs_data;
	logic [31:0] rt_data;
	logic [4:0]  rf_waddr;
	logic [31:0] rf_wdata;
	logic [31:0] alu_result;
	logic        alu_equal;
	logic [31:0] dm_rdata;

	// Fetch

	pc_unit pc_unit (
		.clk      (clk),
		.arst_n   (arst_n),
		.run      (run),
		.instr    (instr),
		.npc_mode (ctrl.npc_mode),
		.equal    (alu_equal),
		.imm_ext  (imm_ext),
		.pc       (pc)
	);

	im #(.IM_AW(IM_AW)) im (
		.clk   (clk),
		.run   (run),
		.load  (load),
		.pc    (pc),
		.instr (instr)
	);

	// Decode and write-back

	control control (
		.instr   (instr),
		.ctrl    (ctrl),
		.imm_ext (imm_ext)
	);

	rf rf (
		.clk        (clk),
		.arst_n     (arst_n),
		.run        (run),
		.instr      (instr),
		.ctrl       (ctrl),
		.alu_result (alu_result),
		.dm_rdata   (dm_rdata),
		.rs_data    (rs_data),
		.rt_data    (rt_data),
		.waddr      (rf_waddr),
		.wdata      (rf_wdata)
	);

	// Execute and memory

	alu alu (
		.ctrl    (ctrl),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.imm_ext (imm_ext),
		.result  (alu_result),
		.equal   (alu_equal)
	);

	dm #(.DM_AW(DM_AW)) dm (
		.clk   (clk),
		.run   (run),
		.load  (load),
		.ctrl  (ctrl),
		.addr  (alu_result),
		.wdata (rt_data),
		.rdata (dm_rdata)
	);

	// Trace of the instruction committed at this edge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			retire_valid <= 1'b0;
		end else begin
			retire_valid <= run;
		end
	end

	always_ff @(posedge clk) begin
		if (run) begin
			retire.pc       <= pc;
			retire.instr    <= instr;
			// Writes to r0 are dropped, so they do not show in the trace
			retire.rf_we    <= ctrl.rf_we && (rf_waddr != 5'd0);
			retire.rf_waddr <= rf_waddr;
			retire.rf_wdata <= rf_wdata;
			retire.dm_we    <= ctrl.dm_we;
			retire.dm_addr  <= alu_result;
			retire.dm_wdata <= rt_data;
		end
	end

endmodule

`default_nettype wire

/* dv/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS = 4
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always begin
		#(PERIOD_NS / 2.0);
		clk = ~clk;
	end

endmodule

`default_nettype wire

/* dv/cpu_ref_model.svh */
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

// Architectural state of the ISA model
logic [31:0] ref_pc;
logic [31:0] ref_regs [32];
logic [31:0] ref_im [2**IM_AW];
logic [31:0] ref_dm [2**DM_AW];

function automatic void clear_arch_state();
	ref_pc = 32'd0;
	for (int i = 0; i < 32; i++) begin
		ref_regs[i] = 32'd0;
	end
endfunction

// r0 is never written, so it keeps reading zero
function automatic void write_reg(inout retire_t r, input logic [4:0] dest,
		input logic [31:0] value);
	if (dest != 5'd0) begin
		r.rf_we       = 1'b1;
		r.rf_waddr    = dest;
		r.rf_wdata    = value;
		ref_regs[dest] = value;
	end
endfunction

// Executes one instruction and returns what it commits
function automatic retire_t execute_next();
	retire_t     r;
	logic [31:0] word;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] imm_s;
	logic [31:0] addr;
	logic [31:0] pc4;
	word    = ref_im[ref_pc[IM_AW+1:2]];
	a       = ref_regs[word[25:21]];
	b       = ref_regs[word[20:16]];
	imm_s   = {{16{word[15]}}, word[15:0]};
	addr    = a + imm_s;
	pc4     = ref_pc + 32'd4;
	r       = '0;
	r.pc    = ref_pc;
	r.instr = instr_t'(word);
	ref_pc  = pc4;
	case (word[31:26])
		op_rtype: begin
			case (word[5:0])
				fn_addu: write_reg(r, word[15:11], a + b);
				fn_subu: write_reg(r, word[15:11], a - b);
				fn_and:  write_reg(r, word[15:11], a & b);
				fn_or:   write_reg(r, word[15:11], a | b);
				fn_slt:  write_reg(r, word[15:11], {31'd0, $signed(a) < $signed(b)});
				default: ;
			endcase
		end
		op_addiu: write_reg(r, word[20:16], a + imm_s);
		op_ori:   write_reg(r, word[20:16], a | {16'h0000, word[15:0]});
		op_lui:   write_reg(r, word[20:16], {word[15:0], 16'h0000});
		op_lw:    write_reg(r, word[20:16], ref_dm[addr[DM_AW+1:2]]);
		op_sw: begin
			r.dm_we    = 1'b1;
			r.dm_addr  = addr;
			r.dm_wdata = b;
			ref_dm[addr[DM_AW+1:2]] = b;
		end
		op_beq: begin
			if (a == b) begin
				ref_pc = pc4 + {imm_s[29:0], 2'b00};
			end
		end
		op_j:    ref_pc = {pc4[31:28], word[25:0], 2'b00};
		default: ;
	endcase
	return r;
endfunction

`endif

/* dv/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

	localparam int IM_AW         = 6;
	localparam int DM_AW         = 6;
	localparam int PROG_WORDS    = 2**IM_AW;
	localparam int DATA_WORDS    = 2**DM_AW;
	localparam int RUN_CYCLES    = 300;
	localparam int RESET_CYCLES  = 2;
	localparam int MAX_STALLS    = 8;
	localparam int MAX_STALL_LEN = 4;
	localparam int CLK_PERIOD_NS = 4;
	// Reset, both loads, the run with its stalls, and some slack
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + PROG_WORDS + DATA_WORDS + RUN_CYCLES
		+ MAX_STALLS * MAX_STALL_LEN + 20;

	logic    clk;
	logic    arst_n;
	logic    run;
	load_t   load;
	logic    retire_valid;
	retire_t retire;

	`include "cpu_ref_model.svh"

	tb_clock #(.PERIOD_NS(CLK_PERIOD_NS)) clock0 (.clk(clk));

	cpu #(.IM_AW(IM_AW), .DM_AW(DM_AW)) dut0 (
		.clk          (clk),
		.arst_n       (arst_n),
		.run          (run),
		.load         (load),
		.retire_valid (retire_valid),
		.retire       (retire)
	);

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic check_pc(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			stop_with_failure($sformatf("Error: %s pc expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic check_valid(input string name, input logic exp, input logic act);
		if (act !== exp && exp) begin
			stop_with_failure($sformatf("In %s a committed instruction gave no retire record",
				name));
		end else if (act !== exp) begin
			stop_with_failure($sformatf("In %s a retire record came with nothing committed",
				name));
		end
	endtask

	// Write fields only count when their enable is set
	function automatic retire_t active_fields(input retire_t r);
		retire_t m;
		m = r;
		if (!m.rf_we) begin
			m.rf_waddr = '0;
			m.rf_wdata = '0;
		end
		if (!m.dm_we) begin
			m.dm_addr  = '0;
			m.dm_wdata = '0;
		end
		return m;
	endfunction

	task automatic check_retire(input string name, input retire_t exp, input retire_t act);
		retire_t e;
		retire_t a;
		e = active_fields(exp);
		a = active_fields(act);
		if (a !== e) begin
			stop_with_failure($sformatf("Error: %s expected %h actual %h", name, e, a));
		end
	endtask

	task automatic check_commit(input logic exp_valid, input retire_t exp, input int n);
		string name;
		name = $sformatf("retire %0d", n);
		check_valid(name, exp_valid, retire_valid);
		if (exp_valid) begin
			check_retire(name, exp, retire);
		end
		check_pc(name, ref_pc, dut0.pc);
	endtask

	task automatic send_load_beat(input load_target_e target, input int idx,
			input logic [31:0] data);
		@(negedge clk);
		check_valid("load", 1'b0, retire_valid);
		check_pc("load", ref_pc, dut0.pc);
		load.valid  = 1'b1;
		load.target = target;
		load.addr   = 32'(idx) << 2;
		load.data   = data;
	endtask

	function automatic logic [31:0] rtype_word(input funct_e fn, input logic [4:0] rs,
			input logic [4:0] rt, input logic [4:0] rd);
		return {op_rtype, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] itype_word(input opcode_e op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jump_word(input logic [25:0] target);
		return {op_j, target};
	endfunction

	function automatic logic [31:0] random_instr(input int idx);
		int          kind;
		int          off;
		logic [31:0] w;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		kind = $urandom_range(0, 99);
		rs   = 5'($urandom_range(0, 7));
		rt   = 5'($urandom_range(0, 7));
		rd   = 5'($urandom_range(0, 7));
		if (kind < 60) begin
			case ($urandom_range(0, 7))
				0: w = rtype_word(fn_addu, rs, rt, rd);
				1: w = rtype_word(fn_subu, rs, rt, rd);
				2: w = rtype_word(fn_and, rs, rt, rd);
				3: w = rtype_word(fn_or, rs, rt, rd);
				4: w = rtype_word(fn_slt, rs, rt, rd);
				5: w = itype_word(op_addiu, rs, rt, 16'($urandom()));
				6: w = itype_word(op_ori, rs, rt, 16'($urandom()));
				default: w = itype_word(op_lui, rs, rt, 16'($urandom()));
			endcase
		end else if (kind < 75) begin
			// Base r0, offsets up to 1 KB wrap around the data memory
			off = $urandom_range(0, 255);
			if ($urandom_range(0, 1) == 0) begin
				w = itype_word(op_lw, 5'd0, rt, 16'(off * 4));
			end else begin
				w = itype_word(op_sw, 5'd0, rt, 16'(off * 4));
			end
		end else if (kind < 85) begin
			off = $urandom_range(0, 6) - 3;
			// A beq onto itself would spin forever
			if (off == -1) begin
				off = 2;
			end
			w = itype_word(op_beq, rs & 5'd3, rt & 5'd3, 16'(off));
		end else if (kind < 90) begin
			off = $urandom_range(0, PROG_WORDS - 1);
			if (off == idx) begin
				off = (idx + 3) % PROG_WORDS;
			end
			w = jump_word(26'(off));
		end else begin
			w = $urandom();
			case ($urandom_range(0, 3))
				0: w[31:26] = 6'h08;
				1: w[31:26] = 6'h0c;
				2: begin
					w[31:26] = 6'h00;
					w[5:0]   = 6'h26;
				end
				default: begin
					w[31:26] = 6'h00;
					w[5:0]   = 6'h00;
				end
			endcase
		end
		return w;
	endfunction

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD_NS);
		stop_with_failure($sformatf("Timeout after %0d cycles, the run never finished",
			WATCHDOG_CYCLES));
	end

	initial begin
		logic [31:0] prog [PROG_WORDS];
		logic [31:0] data [DATA_WORDS];
		retire_t     pending;
		logic        pending_valid;
		int          run_count;
		int          stall_left;
		int          stalls;
		void'($urandom(32'hcddb));
		arst_n      = 1'b0;
		run         = 1'b0;
		load        = '0;
		clear_arch_state();
		for (int i = 0; i < PROG_WORDS; i++) begin
			prog[i] = random_instr(i);
		end
		for (int i = 0; i < DATA_WORDS; i++) begin
			data[i] = $urandom();
		end

		repeat (RESET_CYCLES) @(negedge clk);
		check_valid("reset", 1'b0, retire_valid);
		arst_n = 1'b1;

		// Both memories are filled while the core is stopped
		for (int i = 0; i < PROG_WORDS; i++) begin
			send_load_beat(load_im, i, prog[i]);
			ref_im[i] = prog[i];
		end
		for (int i = 0; i < DATA_WORDS; i++) begin
			send_load_beat(load_dm, i, data[i]);
			ref_dm[i] = data[i];
		end
		@(negedge clk);
		check_valid("load done", 1'b0, retire_valid);
		check_pc("load done", ref_pc, dut0.pc);
		load = '0;

		pending       = '0;
		pending_valid = 1'b0;
		run_count     = 0;
		stall_left    = 0;
		stalls        = 0;
		while (run_count < RUN_CYCLES) begin
			@(negedge clk);
			check_commit(pending_valid, pending, run_count);
			if (stall_left == 0 && stalls < MAX_STALLS && run_count > 0
					&& $urandom_range(0, 39) == 0) begin
				stall_left = $urandom_range(1, MAX_STALL_LEN);
				stalls++;
			end
			load = '0;
			if (stall_left > 0) begin
				run = 1'b0;
				stall_left--;
			end else begin
				run     = 1'b1;
				pending = execute_next();
				run_count++;
				// Loader beats while running must be ignored
				if ($urandom_range(0, 15) == 0) begin
					load.valid  = 1'b1;
					load.target = load_dm;
					load.addr   = $urandom();
					load.data   = $urandom();
				end
			end
			pending_valid = run;
		end
		@(negedge clk);
		check_commit(pending_valid, pending, run_count);
		run  = 1'b0;
		load = '0;
		@(negedge clk);
		check_commit(1'b0, pending, run_count);

		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+dv
source/cpu_pkg.sv
source/pc_unit.sv
source/im.sv
source/control.sv
source/rf.sv
source/alu.sv
source/dm.sv
source/cpu.sv
dv/tb_clock.sv
dv/cpu_tb.sv
